// ==== logic/fe_cfg_pkg.sv ====
`default_nettype none

package fe_cfg_pkg;

  // Address and instruction width
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // Cache line geometry
  localparam int LINE_WORDS  = 4;
  localparam int LINE_LEN    = LINE_WORDS * ILEN;
  // Byte offset inside a line
  localparam int OFFSET_BITS = 4;

  // Global history length, also sets the counter table to 2**HLEN entries
  localparam int HLEN = 4;

  // Index width of the branch target buffer
  localparam int BTB_BITS = 4;

  // First PC fetched after reset
  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0100;

endpackage

`default_nettype wire

// ==== logic/fe_types_pkg.sv ====
`default_nettype none

package fe_types_pkg;

  // Fetch exception causes, numbered as in the privileged spec
  typedef enum logic [3:0] {
    INSTR_ADDR_MISALIGNED = 4'd0,
    INSTR_ACCESS_FAULT    = 4'd1,
    NONE                  = 4'd15
  } except_code_t;

  // Two-bit saturating direction counter
  // MSB set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } ctr_t;

  // Global branch history, newest outcome in bit 0
  typedef logic [fe_cfg_pkg::HLEN-1:0] hist_t;

endpackage

`default_nettype wire

// ==== logic/pc_gen_stage.sv ====
`default_nettype none

module pc_gen_stage (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // Exception redirect from the back end
  input  logic                        except_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] except_pc_i,
  // Branch resolution
  input  logic                        res_valid_i,
  input  logic                        res_mispredict_i,
  input  logic                        res_taken_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] res_pc_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] res_target_i,
  // Prediction for the instruction just fetched
  input  logic                        pred_taken_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] pred_target_i,
  input  logic                        fetch_ready_i,
  output logic [fe_cfg_pkg::XLEN-1:0] pc_o
);

  logic [fe_cfg_pkg::XLEN-1:0] next_pc;

  // Next PC priority
  // exception, then misprediction, then prediction, then sequential
  always_comb begin
    next_pc = pc_o;
    if (except_i) begin
      next_pc = except_pc_i;
    end else if (res_valid_i && res_mispredict_i) begin
      // Wrong direction or wrong target, restart on the real path
      next_pc = res_taken_i ? res_target_i : res_pc_i + 32'd4;
    end else if (fetch_ready_i) begin
      next_pc = pred_taken_i ? pred_target_i : pc_o + 32'd4;
    end
  end

  // PC register, holds until fetch consumes it or a redirect comes in
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o <= fe_cfg_pkg::BOOT_PC;
    end else begin
      pc_o <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== logic/gshare_predictor.sv ====
`default_nettype none

module gshare_predictor (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // Lookup on the PC about to be requested
  input  logic [fe_cfg_pkg::XLEN-1:0] lookup_pc_i,
  // Training from the branch unit
  input  logic                        upd_valid_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] upd_pc_i,
  input  logic                        upd_taken_i,
  output logic                        taken_o
);

  // Counter table, one entry per history value
  fe_types_pkg::ctr_t  ctr_q [2**fe_cfg_pkg::HLEN];
  fe_types_pkg::hist_t hist_q;
  fe_types_pkg::hist_t lookup_idx;
  fe_types_pkg::hist_t upd_idx;

  // Word address bits hashed with the global history
  assign lookup_idx = lookup_pc_i[fe_cfg_pkg::HLEN+1:2] ^ hist_q;
  assign upd_idx    = upd_pc_i[fe_cfg_pkg::HLEN+1:2] ^ hist_q;

  // Taken when the counter sits in the upper half
  assign taken_o = ctr_q[lookup_idx] inside {fe_types_pkg::WEAK_T, fe_types_pkg::STRONG_T};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hist_q <= '0;
      for (int i = 0; i < 2**fe_cfg_pkg::HLEN; i++) begin
        ctr_q[i] <= fe_types_pkg::WEAK_NT;
      end
    end else if (upd_valid_i) begin
      // Outcome enters the history on every resolution
      hist_q <= {hist_q[fe_cfg_pkg::HLEN-2:0], upd_taken_i};
      // Saturate at both ends
      if (upd_taken_i && ctr_q[upd_idx] != fe_types_pkg::STRONG_T) begin
        ctr_q[upd_idx] <= fe_types_pkg::ctr_t'(ctr_q[upd_idx] + 2'b01);
      end else if (!upd_taken_i && ctr_q[upd_idx] != fe_types_pkg::STRONG_NT) begin
        ctr_q[upd_idx] <= fe_types_pkg::ctr_t'(ctr_q[upd_idx] - 2'b01);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/branch_target_buffer.sv ====
`default_nettype none

module branch_target_buffer (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // Lookup port
  input  logic [fe_cfg_pkg::XLEN-1:0] lookup_pc_i,
  // Write port, driven by taken resolutions
  input  logic                        upd_valid_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] upd_pc_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] upd_target_i,
  output logic                        hit_o,
  output logic [fe_cfg_pkg::XLEN-1:0] target_o
);

  localparam int ENTRIES = 2**fe_cfg_pkg::BTB_BITS;
  // Tag covers everything above the index and the byte offset
  localparam int TAG_LEN = fe_cfg_pkg::XLEN - fe_cfg_pkg::BTB_BITS - 2;

  logic [ENTRIES-1:0]              valid_q;
  logic [TAG_LEN-1:0]              tag_q    [ENTRIES];
  logic [fe_cfg_pkg::XLEN-1:0]     target_q [ENTRIES];

  logic [fe_cfg_pkg::BTB_BITS-1:0] lookup_idx;
  logic [fe_cfg_pkg::BTB_BITS-1:0] upd_idx;
  logic [TAG_LEN-1:0]              lookup_tag;
  logic [TAG_LEN-1:0]              upd_tag;

  // Direct mapped on the word address
  assign lookup_idx = lookup_pc_i[fe_cfg_pkg::BTB_BITS+1:2];
  assign upd_idx    = upd_pc_i[fe_cfg_pkg::BTB_BITS+1:2];
  assign lookup_tag = lookup_pc_i[fe_cfg_pkg::XLEN-1:fe_cfg_pkg::BTB_BITS+2];
  assign upd_tag    = upd_pc_i[fe_cfg_pkg::XLEN-1:fe_cfg_pkg::BTB_BITS+2];

  assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign target_o = target_q[lookup_idx];

  // Valid bits, the only state cleared by reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Tag and target storage, a new branch simply evicts the old one
  always_ff @(posedge clk_i) begin
    if (upd_valid_i) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= upd_target_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            flush_i,
  // PC generator
  input  logic [fe_cfg_pkg::XLEN-1:0]     pc_i,
  output logic                            fetch_ready_o,
  output logic                            pred_taken_o,
  output logic [fe_cfg_pkg::XLEN-1:0]     pred_target_o,
  // Instruction cache request
  output logic [fe_cfg_pkg::XLEN-1:0]     addr_o,
  output logic                            addr_valid_o,
  input  logic                            addr_ready_i,
  // Instruction cache answer
  output logic                            data_ready_o,
  input  logic                            ans_valid_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]     ans_vaddr_i,
  input  logic [fe_cfg_pkg::LINE_LEN-1:0] ans_line_i,
  input  logic                            ans_fault_i,
  // Decode
  input  logic                            issue_ready_i,
  output logic                            issue_valid_o,
  output logic [fe_cfg_pkg::ILEN-1:0]     instruction_o,
  output logic [fe_cfg_pkg::XLEN-1:0]     curr_pc_o,
  output logic                            except_o,
  output fe_types_pkg::except_code_t      except_code_o,
  // Branch unit resolution, trains the predictor
  input  logic                            res_valid_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]     res_pc_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]     res_target_i,
  input  logic                            res_taken_i
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT} state_t;

  state_t                                 state_q;
  // Answer still owed by the cache for a flushed request
  logic                                   drop_q;
  // Request address and the prediction made for it
  logic [fe_cfg_pkg::XLEN-1:0]            req_pc_q;
  logic                                   req_taken_q;
  logic [fe_cfg_pkg::XLEN-1:0]            req_target_q;

  logic                                   gshare_taken;
  logic                                   btb_hit;
  logic                                   btb_upd;
  logic [fe_cfg_pkg::XLEN-1:0]            btb_target;
  logic                                   lookup_taken;
  logic [fe_cfg_pkg::XLEN-1:0]            lookup_target;
  logic                                   out_free;
  logic                                   misaligned;
  logic                                   start;
  logic                                   ans_take;
  logic                                   load_ans;
  logic                                   load_mis;
  logic [$clog2(fe_cfg_pkg::LINE_WORDS)-1:0] word_sel;

  gshare_predictor u_gshare (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .lookup_pc_i (pc_i),
    .upd_valid_i (res_valid_i),
    .upd_pc_i    (res_pc_i),
    .upd_taken_i (res_taken_i),
    .taken_o     (gshare_taken)
  );

  // Only taken branches get a target entry
  assign btb_upd = res_valid_i && res_taken_i;

  branch_target_buffer u_btb (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .lookup_pc_i  (pc_i),
    .upd_valid_i  (btb_upd),
    .upd_pc_i     (res_pc_i),
    .upd_target_i (res_target_i),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  // Taken needs both the direction and a known target
  assign lookup_taken  = gshare_taken && btb_hit;
  assign lookup_target = lookup_taken ? btb_target : pc_i + 32'd4;

  // Output register empty or emptied this cycle
  assign out_free   = !issue_valid_o || issue_ready_i;
  assign misaligned = (pc_i[1:0] != 2'b00);

  // PC is stale while the fetch_ready pulse is out
  assign start = (state_q == IDLE) && !drop_q && !fetch_ready_o && !flush_i && out_free;

  // Misaligned PC never reaches the cache
  assign load_mis = start && misaligned;

  assign addr_o       = req_pc_q;
  assign addr_valid_o = (state_q == REQ);
  assign data_ready_o = (state_q == WAIT) || drop_q;

  assign ans_take = ans_valid_i && data_ready_o;
  // A flushed or dropped answer is discarded
  assign load_ans = ans_take && (state_q == WAIT) && !flush_i;

  assign word_sel = req_pc_q[fe_cfg_pkg::OFFSET_BITS-1:2];

  // Request FSM and drop tracking
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= IDLE;
      drop_q        <= 1'b0;
      fetch_ready_o <= 1'b0;
    end else begin
      fetch_ready_o <= load_ans || load_mis;
      if (flush_i) begin
        state_q <= IDLE;
        // Accepted request without its answer yet
        drop_q  <= ((state_q == WAIT) && !ans_take) ||
                   ((state_q == REQ) && addr_ready_i) ||
                   (drop_q && !ans_take);
      end else begin
        if (drop_q && ans_take) begin
          drop_q <= 1'b0;
        end
        case (state_q)
          IDLE: begin
            if (start && !misaligned) begin
              state_q <= REQ;
            end
          end
          REQ: begin
            if (addr_ready_i) begin
              state_q <= WAIT;
            end
          end
          WAIT: begin
            if (ans_take) begin
              state_q <= IDLE;
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  // Request address and prediction are captured together
  always_ff @(posedge clk_i) begin
    if (start) begin
      req_pc_q     <= pc_i;
      req_taken_q  <= lookup_taken;
      req_target_q <= lookup_target;
    end
  end

  // Output register control part
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_valid_o <= 1'b0;
      except_o      <= 1'b0;
      except_code_o <= fe_types_pkg::NONE;
    end else if (flush_i) begin
      issue_valid_o <= 1'b0;
      except_o      <= 1'b0;
      except_code_o <= fe_types_pkg::NONE;
    end else if (load_mis) begin
      issue_valid_o <= 1'b1;
      except_o      <= 1'b1;
      except_code_o <= fe_types_pkg::INSTR_ADDR_MISALIGNED;
    end else if (load_ans) begin
      issue_valid_o <= 1'b1;
      except_o      <= ans_fault_i;
      except_code_o <= ans_fault_i ? fe_types_pkg::INSTR_ACCESS_FAULT : fe_types_pkg::NONE;
    end else if (issue_ready_i) begin
      // Drained by decode
      issue_valid_o <= 1'b0;
      except_o      <= 1'b0;
      except_code_o <= fe_types_pkg::NONE;
    end
  end

  // Output register payload
  always_ff @(posedge clk_i) begin
    if (load_mis) begin
      instruction_o <= '0;
      curr_pc_o     <= pc_i;
      pred_taken_o  <= lookup_taken;
      pred_target_o <= lookup_target;
    end else if (load_ans) begin
      // Faulting line carries no usable word
      instruction_o <= ans_fault_i ? '0 : ans_line_i[word_sel*fe_cfg_pkg::ILEN +: fe_cfg_pkg::ILEN];
      // Line address from the cache, offset from the request
      curr_pc_o     <= {ans_vaddr_i[fe_cfg_pkg::XLEN-1:fe_cfg_pkg::OFFSET_BITS],
                        req_pc_q[fe_cfg_pkg::OFFSET_BITS-1:0]};
      pred_taken_o  <= req_taken_q;
      pred_target_o <= req_target_q;
    end
  end

endmodule

`default_nettype wire

// ==== logic/frontend.sv ====
`default_nettype none

module frontend (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            flush_i,
  // Instruction cache
  output logic [fe_cfg_pkg::XLEN-1:0]     addr_o,
  output logic                            addr_valid_o,
  input  logic                            addr_ready_i,
  output logic                            data_ready_o,
  input  logic                            ans_valid_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]     ans_vaddr_i,
  input  logic [fe_cfg_pkg::LINE_LEN-1:0] ans_line_i,
  input  logic                            ans_fault_i,
  // Decode
  input  logic                            issue_ready_i,
  output logic                            issue_valid_o,
  output logic [fe_cfg_pkg::ILEN-1:0]     instruction_o,
  output logic [fe_cfg_pkg::XLEN-1:0]     curr_pc_o,
  output logic                            pred_taken_o,
  output logic [fe_cfg_pkg::XLEN-1:0]     pred_target_o,
  output logic                            except_o,
  output fe_types_pkg::except_code_t      except_code_o,
  // Branch unit
  input  logic                            res_valid_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]     res_pc_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]     res_target_i,
  input  logic                            res_taken_i,
  input  logic                            res_mispredict_i,
  // Exception redirect
  input  logic                            except_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]     except_pc_i
);

  logic                        fetch_ready;
  logic                        flush;
  logic [fe_cfg_pkg::XLEN-1:0] pc;

  // Any redirect empties the fetch path
  assign flush = flush_i || except_i || (res_valid_i && res_mispredict_i);

  fetch_stage u_fetch_stage (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush),
    .pc_i          (pc),
    .fetch_ready_o (fetch_ready),
    .pred_taken_o  (pred_taken_o),
    .pred_target_o (pred_target_o),
    .addr_o        (addr_o),
    .addr_valid_o  (addr_valid_o),
    .addr_ready_i  (addr_ready_i),
    .data_ready_o  (data_ready_o),
    .ans_valid_i   (ans_valid_i),
    .ans_vaddr_i   (ans_vaddr_i),
    .ans_line_i    (ans_line_i),
    .ans_fault_i   (ans_fault_i),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .instruction_o (instruction_o),
    .curr_pc_o     (curr_pc_o),
    .except_o      (except_o),
    .except_code_o (except_code_o),
    .res_valid_i   (res_valid_i),
    .res_pc_i      (res_pc_i),
    .res_target_i  (res_target_i),
    .res_taken_i   (res_taken_i)
  );

  // Prediction goes to decode and back to the PC generator
  pc_gen_stage u_pc_gen_stage (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .except_i         (except_i),
    .except_pc_i      (except_pc_i),
    .res_valid_i      (res_valid_i),
    .res_mispredict_i (res_mispredict_i),
    .res_taken_i      (res_taken_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .pred_taken_i     (pred_taken_o),
    .pred_target_i    (pred_target_o),
    .fetch_ready_i    (fetch_ready),
    .pc_o             (pc)
  );

endmodule

`default_nettype wire

// ==== bench/tb_frontend.sv ====
`default_nettype none

module tb_frontend;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 6;
  // Model memory covers byte addresses 0 to 4 KiB
  localparam int MEM_WORDS    = 1024;

  // Branch used for training, its target and a branch that only fills the history
  localparam logic [31:0] BR_PC     = 32'h0000_0300;
  localparam logic [31:0] BR_TARGET = 32'h0000_0340;
  localparam logic [31:0] FILL_PC   = 32'h0000_0804;
  localparam logic [31:0] FAULT_PC  = 32'h0000_0500;

  // One instruction as decode saw it
  typedef struct packed {
    logic [fe_cfg_pkg::XLEN-1:0] pc;
    logic [fe_cfg_pkg::ILEN-1:0] instr;
    logic                        taken;
    logic [fe_cfg_pkg::XLEN-1:0] target;
    fe_types_pkg::except_code_t  code;
  } issue_t;

  logic                            clk_i;
  logic                            arst_n_i;
  logic                            flush_i;
  logic [fe_cfg_pkg::XLEN-1:0]     addr_o;
  logic                            addr_valid_o;
  logic                            addr_ready_i;
  logic                            data_ready_o;
  logic                            ans_valid_i;
  logic [fe_cfg_pkg::XLEN-1:0]     ans_vaddr_i;
  logic [fe_cfg_pkg::LINE_LEN-1:0] ans_line_i;
  logic                            ans_fault_i;
  logic                            issue_ready_i;
  logic                            issue_valid_o;
  logic [fe_cfg_pkg::ILEN-1:0]     instruction_o;
  logic [fe_cfg_pkg::XLEN-1:0]     curr_pc_o;
  logic                            pred_taken_o;
  logic [fe_cfg_pkg::XLEN-1:0]     pred_target_o;
  logic                            except_o;
  fe_types_pkg::except_code_t      except_code_o;
  logic                            res_valid_i;
  logic [fe_cfg_pkg::XLEN-1:0]     res_pc_i;
  logic [fe_cfg_pkg::XLEN-1:0]     res_target_i;
  logic                            res_taken_i;
  logic                            res_mispredict_i;
  logic                            except_i;
  logic [fe_cfg_pkg::XLEN-1:0]     except_pc_i;

  int                              seed = 32'h398634b4;
  int                              errors = 0;
  issue_t                          issue_q[$];
  logic [fe_cfg_pkg::ILEN-1:0]     mem [MEM_WORDS];
  // Optional faulting line of the cache model
  logic                            fault_en;
  logic [fe_cfg_pkg::XLEN-1:0]     fault_line;
  // Next PC expected in straight-line flow
  logic [fe_cfg_pkg::XLEN-1:0]     next_pc;

  frontend UUT (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .flush_i          (flush_i),
    .addr_o           (addr_o),
    .addr_valid_o     (addr_valid_o),
    .addr_ready_i     (addr_ready_i),
    .data_ready_o     (data_ready_o),
    .ans_valid_i      (ans_valid_i),
    .ans_vaddr_i      (ans_vaddr_i),
    .ans_line_i       (ans_line_i),
    .ans_fault_i      (ans_fault_i),
    .issue_ready_i    (issue_ready_i),
    .issue_valid_o    (issue_valid_o),
    .instruction_o    (instruction_o),
    .curr_pc_o        (curr_pc_o),
    .pred_taken_o     (pred_taken_o),
    .pred_target_o    (pred_target_o),
    .except_o         (except_o),
    .except_code_o    (except_code_o),
    .res_valid_i      (res_valid_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .res_taken_i      (res_taken_i),
    .res_mispredict_i (res_mispredict_i),
    .except_i         (except_i),
    .except_pc_i      (except_pc_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Every word differs and depends on its full byte address
  initial begin : mem_fill
    logic [31:0] addr;
    for (int i = 0; i < MEM_WORDS; i++) begin
      addr   = i * 4;
      mem[i] = (addr << 16) ^ addr ^ 32'h0000_0013;
    end
  end

  function automatic logic [fe_cfg_pkg::ILEN-1:0] word_at(input logic [31:0] addr);
    return mem[addr[11:2]];
  endfunction

  // Word k of a line sits at bits k*ILEN upward
  function automatic logic [fe_cfg_pkg::LINE_LEN-1:0] line_at(input logic [31:0] line_addr);
    logic [fe_cfg_pkg::LINE_LEN-1:0] line;
    for (int k = 0; k < fe_cfg_pkg::LINE_WORDS; k++) begin
      line[k*fe_cfg_pkg::ILEN +: fe_cfg_pkg::ILEN] = word_at(line_addr + k * 4);
    end
    return line;
  endfunction

  // Cache model with one request at a time and a latency of 1 to 4 cycles
  // Handshakes are sampled at the falling edge, where everything is settled
  initial begin : cache_model
    logic [fe_cfg_pkg::XLEN-1:0] line_addr;
    logic [31:0]                 rnd;
    forever begin
      @(negedge clk_i);
      rnd = $random(seed);
      if (addr_valid_o && addr_ready_i) begin
        line_addr = {addr_o[fe_cfg_pkg::XLEN-1:fe_cfg_pkg::OFFSET_BITS],
                     {fe_cfg_pkg::OFFSET_BITS{1'b0}}};
        // Edge that accepts the request
        @(posedge clk_i);
        repeat (rnd[1:0]) @(posedge clk_i);
        #(DRIVE_DELAY);
        ans_valid_i = 1'b1;
        ans_vaddr_i = line_addr;
        ans_line_i  = line_at(line_addr);
        ans_fault_i = fault_en && (line_addr == fault_line);
        // Hold the answer until the front end takes it
        @(negedge clk_i);
        while (!data_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #(DRIVE_DELAY);
        ans_valid_i = 1'b0;
        ans_fault_i = 1'b0;
      end else begin
        // Request port busy in about one cycle of four
        @(posedge clk_i);
        #(DRIVE_DELAY);
        addr_ready_i = (rnd[3:2] != 2'b00);
      end
    end
  end

  // Decode side monitor that records what is consumed on the next edge
  always @(negedge clk_i) begin
    if (arst_n_i && issue_valid_o && issue_ready_i) begin
      issue_q.push_back({curr_pc_o, instruction_o, pred_taken_o, pred_target_o, except_code_o});
      if (except_o != (except_code_o != fe_types_pkg::NONE)) begin
        $display("Exception flag disagrees with the exception code at PC %h", curr_pc_o);
        errors++;
      end
    end
  end

  task automatic check_fetch(
    input string                       name,
    input logic [fe_cfg_pkg::ILEN-1:0] exp_instr,
    input logic [fe_cfg_pkg::XLEN-1:0] exp_pc,
    input logic                        exp_taken,
    input logic [fe_cfg_pkg::XLEN-1:0] exp_target,
    input issue_t                      act
  );
    if (act.pc !== exp_pc) begin
      $display("ERR %s: pc expected %h, got %h", name, exp_pc, act.pc);
      errors++;
    end
    if (act.instr !== exp_instr) begin
      $display("ERR %s: instruction expected %h, got %h", name, exp_instr, act.instr);
      errors++;
    end
    if (act.taken !== exp_taken) begin
      $display("ERR %s: pred_taken expected %b, got %b", name, exp_taken, act.taken);
      errors++;
    end
    if (act.target !== exp_target) begin
      $display("ERR %s: pred_target expected %h, got %h", name, exp_target, act.target);
      errors++;
    end
  endtask

  task automatic check_except(
    input string                      name,
    input fe_types_pkg::except_code_t exp,
    input fe_types_pkg::except_code_t act
  );
    if (act !== exp) begin
      $display("ERR %s: except code expected %s, got %s (%0d)", name, exp.name(), act.name(),
               act);
      errors++;
    end
  endtask

  // Waits for the next issued instruction and checks it
  task automatic expect_issue(
    input string                       name,
    input logic [fe_cfg_pkg::XLEN-1:0] pc,
    input logic                        taken,
    input logic [fe_cfg_pkg::XLEN-1:0] target,
    input fe_types_pkg::except_code_t  code
  );
    issue_t                      item;
    logic [fe_cfg_pkg::ILEN-1:0] exp_instr;
    while (issue_q.size() == 0) @(negedge clk_i);
    item = issue_q.pop_front();
    // Excepting fetches carry a zero instruction
    exp_instr = (code == fe_types_pkg::NONE) ? word_at(pc) : '0;
    check_fetch(name, exp_instr, pc, taken, target, item);
    check_except(name, code, item.code);
  endtask

  // Plain fetch with nothing predicted and a fall-through target
  task automatic expect_seq(input string name, input logic [fe_cfg_pkg::XLEN-1:0] pc);
    expect_issue(name, pc, 1'b0, pc + 32'd4, fe_types_pkg::NONE);
  endtask

  // One-cycle redirect with decode stalled, so nothing older slips through
  task automatic pulse_redirect(input logic is_except, input logic [fe_cfg_pkg::XLEN-1:0] pc);
    @(posedge clk_i);
    #(DRIVE_DELAY);
    issue_ready_i = 1'b0;
    if (is_except) begin
      except_i    = 1'b1;
      except_pc_i = pc;
    end else begin
      // Not-taken mispredict of a branch at pc
      res_valid_i      = 1'b1;
      res_pc_i         = pc;
      res_target_i     = pc + 32'h40;
      res_taken_i      = 1'b0;
      res_mispredict_i = 1'b1;
    end
    @(posedge clk_i);
    #(DRIVE_DELAY);
    except_i         = 1'b0;
    res_valid_i      = 1'b0;
    res_mispredict_i = 1'b0;
    issue_q.delete();
    issue_ready_i = 1'b1;
  endtask

  task automatic resolve_taken(
    input logic [fe_cfg_pkg::XLEN-1:0] pc,
    input logic [fe_cfg_pkg::XLEN-1:0] target
  );
    @(posedge clk_i);
    #(DRIVE_DELAY);
    res_valid_i      = 1'b1;
    res_pc_i         = pc;
    res_target_i     = target;
    res_taken_i      = 1'b1;
    res_mispredict_i = 1'b0;
    @(posedge clk_i);
    #(DRIVE_DELAY);
    res_valid_i = 1'b0;
  endtask

  task automatic test_sequential();
    next_pc = fe_cfg_pkg::BOOT_PC;
    for (int i = 0; i < 8; i++) begin
      expect_seq("sequential", next_pc);
      next_pc = next_pc + 32'd4;
    end
  endtask

  // Decode ready toggles in random stretches of 1 to 4 cycles
  task automatic test_backpressure();
    logic [31:0] rnd;
    int          hold;
    int          got;
    hold = 0;
    got  = 0;
    while (got < 12) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      if (hold == 0) begin
        rnd           = $random(seed);
        issue_ready_i = rnd[0];
        hold          = 1 + int'(rnd[3:2]);
      end
      hold--;
      while (issue_q.size() > 0 && got < 12) begin
        expect_seq("backpressure", next_pc);
        next_pc = next_pc + 32'd4;
        got++;
      end
    end
    issue_ready_i = 1'b1;
  endtask

  task automatic test_except_redirect();
    pulse_redirect(1'b1, 32'h0000_0200);
    for (int i = 0; i < 4; i++) begin
      expect_seq("except_redirect", 32'h0000_0200 + i * 4);
    end
    // Misaligned target never reaches the cache
    pulse_redirect(1'b1, 32'h0000_0202);
    expect_issue("except_misaligned", 32'h0000_0202, 1'b0, 32'h0000_0206,
                 fe_types_pkg::INSTR_ADDR_MISALIGNED);
  endtask

  task automatic test_predictor_training();
    // Four taken outcomes leave the history all ones
    for (int i = 0; i < 4; i++) begin
      resolve_taken(FILL_PC, 32'h0000_0900);
    end
    // Same history, so both updates hit one counter
    resolve_taken(BR_PC, BR_TARGET);
    resolve_taken(BR_PC, BR_TARGET);
    pulse_redirect(1'b1, BR_PC - 32'd8);
    expect_seq("train", BR_PC - 32'd8);
    expect_seq("train", BR_PC - 32'd4);
    expect_issue("train_branch", BR_PC, 1'b1, BR_TARGET, fe_types_pkg::NONE);
    expect_seq("train_target", BR_TARGET);
    expect_seq("train_target", BR_TARGET + 32'd4);
  endtask

  task automatic test_mispredict_redirect();
    pulse_redirect(1'b0, BR_PC);
    expect_seq("mispredict", BR_PC + 32'd4);
    expect_seq("mispredict", BR_PC + 32'd8);
  endtask

  task automatic test_access_fault();
    fault_line = FAULT_PC;
    fault_en   = 1'b1;
    pulse_redirect(1'b1, FAULT_PC);
    expect_issue("access_fault", FAULT_PC, 1'b0, FAULT_PC + 32'd4,
                 fe_types_pkg::INSTR_ACCESS_FAULT);
    fault_en = 1'b0;
  endtask

  initial begin : main
    arst_n_i         = 1'b0;
    flush_i          = 1'b0;
    addr_ready_i     = 1'b1;
    ans_valid_i      = 1'b0;
    ans_vaddr_i      = '0;
    ans_line_i       = '0;
    ans_fault_i      = 1'b0;
    issue_ready_i    = 1'b0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    except_i         = 1'b0;
    except_pc_i      = '0;
    fault_en         = 1'b0;
    fault_line       = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    if (addr_valid_o || data_ready_o || issue_valid_o || except_o) begin
      $display("Front end outputs are not idle during reset");
      errors++;
    end
    #(DRIVE_DELAY);
    arst_n_i      = 1'b1;
    issue_ready_i = 1'b1;
    test_sequential();
    test_backpressure();
    test_except_redirect();
    test_predictor_training();
    test_mispredict_redirect();
    test_access_fault();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // About 200 cycles allowed per test
  initial begin : watchdog
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog expired before the tests finished, %0d errors so far", errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/fe_cfg_pkg.sv
logic/fe_types_pkg.sv
logic/pc_gen_stage.sv
logic/gshare_predictor.sv
logic/branch_target_buffer.sv
logic/fetch_stage.sv
logic/frontend.sv
bench/tb_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_frontend
RTL_TOP   ?= frontend
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
